// ==== rv_de_cfg.svh ====
`ifndef RV_DE_CFG_SVH
`define RV_DE_CFG_SVH

// data path width, RV32 only
`define RV_DE_XLEN 32

// architectural registers x0..x31
`define RV_DE_NREGS 32

// pc held in execute while in reset
`define RV_DE_RESET_PC 'h0

`endif

// ==== rv_de_pkg.sv ====
`include "rv_de_cfg.svh"

package rv_de_pkg;

    // one data word
    typedef logic [`RV_DE_XLEN-1:0] word_t;

    // register index, x0..x31
    typedef logic [4:0] reg_addr_t;

    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_SLT = 4'd5, // signed compare
        ALU_SLL = 4'd6,
        ALU_SRL = 4'd7
    } alu_op_t;

    // what the writeback stage will pick up
    typedef enum logic [1:0] {
        RES_ALU       = 2'd0,
        RES_MEM       = 2'd1, // load data, not known until mem stage
        RES_PC_PLUS_4 = 2'd2  // link value of jal
    } result_src_t;

endpackage

// ==== instr_decoder.sv ====
`timescale 1ns/1ps
`include "rv_de_cfg.svh"

module instr_decoder (
    input  rv_de_pkg::word_t       instr_i,
    input  logic                   instr_valid_i,
    output logic                   reg_wr_en_o,
    output logic                   mem_wr_en_o,
    output logic                   branch_o,
    output logic                   branch_ne_o,
    output logic                   jump_o,
    output logic                   alu_src_o,
    output rv_de_pkg::result_src_t result_src_o,
    output rv_de_pkg::alu_op_t     alu_op_o,
    output rv_de_pkg::word_t       imm_ext_o,
    output rv_de_pkg::reg_addr_t   rs1_addr_o,
    output rv_de_pkg::reg_addr_t   rs2_addr_o,
    output rv_de_pkg::reg_addr_t   rd_addr_o,
    output logic                   illegal_o
);

    localparam logic [6:0] OP_R_TYPE = 7'b0110011;
    localparam logic [6:0] OP_I_ALU  = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;

    logic [6:0]       opcode;
    logic [2:0]       funct3;
    logic             funct7_5;
    logic             unknown_op;
    rv_de_pkg::word_t imm_i;
    rv_de_pkg::word_t imm_s;
    rv_de_pkg::word_t imm_b;
    rv_de_pkg::word_t imm_j;

    // sub only exists in the R-type encoding
    function automatic rv_de_pkg::alu_op_t alu_op_sel(input logic [2:0] f3, input logic sub_sel);
        rv_de_pkg::alu_op_t op;
        case (f3)
            3'b000:  op = sub_sel ? rv_de_pkg::ALU_SUB : rv_de_pkg::ALU_ADD;
            3'b001:  op = rv_de_pkg::ALU_SLL;
            3'b010:  op = rv_de_pkg::ALU_SLT;
            3'b100:  op = rv_de_pkg::ALU_XOR;
            3'b101:  op = rv_de_pkg::ALU_SRL;
            3'b110:  op = rv_de_pkg::ALU_OR;
            3'b111:  op = rv_de_pkg::ALU_AND;
            default: op = rv_de_pkg::ALU_ADD; // sltu not supported
        endcase
        return op;
    endfunction

    assign opcode   = instr_i[6:0];
    assign funct3   = instr_i[14:12];
    assign funct7_5 = instr_i[30];

    assign rs1_addr_o = instr_i[19:15];
    assign rs2_addr_o = instr_i[24:20];
    assign rd_addr_o  = instr_i[11:7];

    assign imm_i = {{(`RV_DE_XLEN-12){instr_i[31]}}, instr_i[31:20]};
    assign imm_s = {{(`RV_DE_XLEN-12){instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b = {{(`RV_DE_XLEN-12){instr_i[31]}}, instr_i[7], instr_i[30:25],
                    instr_i[11:8], 1'b0};
    assign imm_j = {{(`RV_DE_XLEN-20){instr_i[31]}}, instr_i[19:12], instr_i[20],
                    instr_i[30:21], 1'b0};

    always_comb begin
        reg_wr_en_o  = 1'b0;
        mem_wr_en_o  = 1'b0;
        branch_o     = 1'b0;
        branch_ne_o  = 1'b0;
        jump_o       = 1'b0;
        alu_src_o    = 1'b0;
        result_src_o = rv_de_pkg::RES_ALU;
        alu_op_o     = rv_de_pkg::ALU_ADD;
        imm_ext_o    = imm_i;
        unknown_op   = 1'b0;
        case (opcode)
            OP_R_TYPE: begin
                reg_wr_en_o = 1'b1;
                alu_op_o    = alu_op_sel(funct3, funct7_5);
            end
            OP_I_ALU: begin
                reg_wr_en_o = 1'b1;
                alu_src_o   = 1'b1;
                alu_op_o    = alu_op_sel(funct3, 1'b0);
            end
            OP_LOAD: begin // address only
                reg_wr_en_o  = 1'b1;
                alu_src_o    = 1'b1;
                result_src_o = rv_de_pkg::RES_MEM;
            end
            OP_STORE: begin
                mem_wr_en_o = 1'b1;
                alu_src_o   = 1'b1;
                imm_ext_o   = imm_s;
            end
            OP_BRANCH: begin
                branch_o    = 1'b1;
                branch_ne_o = funct3[0]; // beq 000, bne 001
                alu_op_o    = rv_de_pkg::ALU_SUB;
                imm_ext_o   = imm_b;
            end
            OP_JAL: begin
                reg_wr_en_o  = 1'b1;
                jump_o       = 1'b1;
                result_src_o = rv_de_pkg::RES_PC_PLUS_4;
                imm_ext_o    = imm_j;
            end
            default: unknown_op = 1'b1;
        endcase
        if (!instr_valid_i) begin
            reg_wr_en_o = 1'b0;
            mem_wr_en_o = 1'b0;
        end
    end

    assign illegal_o = instr_valid_i && unknown_op;

endmodule

// ==== reg_file.sv ====
`timescale 1ns/1ps
`include "rv_de_cfg.svh"

module reg_file (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  rv_de_pkg::reg_addr_t rs1_addr_i,
    input  rv_de_pkg::reg_addr_t rs2_addr_i,
    output rv_de_pkg::word_t     rs1_data_o,
    output rv_de_pkg::word_t     rs2_data_o,
    input  logic                 wr_en_i,
    input  rv_de_pkg::reg_addr_t wr_addr_i,
    input  rv_de_pkg::word_t     wr_data_i
);

    rv_de_pkg::word_t regs [`RV_DE_NREGS];
    logic             wr_active;

    assign wr_active = wr_en_i && (wr_addr_i != '0); // x0 never written

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < `RV_DE_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_active) begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

    // writeback in the same cycle wins over the stored value
    assign rs1_data_o = (wr_active && (wr_addr_i == rs1_addr_i)) ? wr_data_i : regs[rs1_addr_i];
    assign rs2_data_o = (wr_active && (wr_addr_i == rs2_addr_i)) ? wr_data_i : regs[rs2_addr_i];

    a_x0_reads_zero: assert property (@(posedge clk) disable iff (!arst_n_i)
        ((rs1_addr_i != '0) || (rs1_data_o == '0)) &&
        ((rs2_addr_i != '0) || (rs2_data_o == '0)))
        else $error("reg_file: x0 read returned nonzero");

endmodule

// ==== pipeline_reg_d_e.sv ====
`timescale 1ns/1ps
`include "rv_de_cfg.svh"

module pipeline_reg_d_e (
    input  logic                   clk,
    input  logic                   arst_n_i,
    input  logic                   flush_i,
    input  logic                   valid_i,
    // decode side
    input  logic                   reg_wr_en_i,
    input  logic                   mem_wr_en_i,
    input  logic                   branch_i,
    input  logic                   branch_ne_i,
    input  logic                   jump_i,
    input  logic                   alu_src_i,
    input  rv_de_pkg::result_src_t result_src_i,
    input  rv_de_pkg::alu_op_t     alu_op_i,
    input  rv_de_pkg::word_t       imm_ext_i,
    input  rv_de_pkg::reg_addr_t   rd_addr_i,
    input  rv_de_pkg::word_t       rs1_data_i,
    input  rv_de_pkg::word_t       rs2_data_i,
    input  rv_de_pkg::word_t       pc_i,
    input  rv_de_pkg::word_t       pc_plus_4_i,
    // execute side
    output logic                   reg_wr_en_o,
    output logic                   mem_wr_en_o,
    output logic                   branch_o,
    output logic                   branch_ne_o,
    output logic                   jump_o,
    output logic                   alu_src_o,
    output rv_de_pkg::result_src_t result_src_o,
    output rv_de_pkg::alu_op_t     alu_op_o,
    output rv_de_pkg::word_t       imm_ext_o,
    output rv_de_pkg::reg_addr_t   rd_addr_o,
    output rv_de_pkg::word_t       rs1_data_o,
    output rv_de_pkg::word_t       rs2_data_o,
    output rv_de_pkg::word_t       pc_o,
    output rv_de_pkg::word_t       pc_plus_4_o
);

    logic keep_ctrl;

    assign keep_ctrl = valid_i && !flush_i; // otherwise a bubble enters execute

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            reg_wr_en_o  <= 1'b0;
            mem_wr_en_o  <= 1'b0;
            branch_o     <= 1'b0;
            branch_ne_o  <= 1'b0;
            jump_o       <= 1'b0;
            alu_src_o    <= 1'b0;
            result_src_o <= rv_de_pkg::RES_ALU;
            alu_op_o     <= rv_de_pkg::ALU_ADD;
            imm_ext_o    <= '0;
            rd_addr_o    <= '0;
            rs1_data_o   <= '0;
            rs2_data_o   <= '0;
            pc_o         <= `RV_DE_RESET_PC;
            pc_plus_4_o  <= '0;
        end else begin
            reg_wr_en_o  <= keep_ctrl && reg_wr_en_i;
            mem_wr_en_o  <= keep_ctrl && mem_wr_en_i;
            branch_o     <= keep_ctrl && branch_i;
            jump_o       <= keep_ctrl && jump_i;
            result_src_o <= keep_ctrl ? result_src_i : rv_de_pkg::RES_ALU;

            // payload follows decode unconditionally
            branch_ne_o <= branch_ne_i;
            alu_src_o   <= alu_src_i;
            alu_op_o    <= alu_op_i;
            imm_ext_o   <= imm_ext_i;
            rd_addr_o   <= rd_addr_i;
            rs1_data_o  <= rs1_data_i;
            rs2_data_o  <= rs2_data_i;
            pc_o        <= pc_i;
            pc_plus_4_o <= pc_plus_4_i;
        end
    end

    a_flush_bubble: assert property (@(posedge clk) disable iff (!arst_n_i)
        flush_i |=> (!reg_wr_en_o && !mem_wr_en_o && !branch_o && !jump_o))
        else $error("pipeline_reg_d_e: write enable survived a flush");

endmodule

// ==== hazard_unit.sv ====
`timescale 1ns/1ps

module hazard_unit (
    input  rv_de_pkg::reg_addr_t   rs1_addr_d_i,
    input  rv_de_pkg::reg_addr_t   rs2_addr_d_i,
    input  rv_de_pkg::reg_addr_t   rd_addr_e_i,
    input  logic                   reg_wr_en_e_i,
    input  rv_de_pkg::result_src_t result_src_e_i,
    input  logic                   branch_taken_e_i,
    output logic                   stall_o,
    output logic                   flush_e_o
);

    logic load_in_e;
    logic src_match;
    logic load_use;

    always_comb begin
        load_in_e = (result_src_e_i == rv_de_pkg::RES_MEM) && reg_wr_en_e_i &&
                    (rd_addr_e_i != '0);
        // both fields compared even if unused by the instruction
        src_match = (rd_addr_e_i == rs1_addr_d_i) || (rd_addr_e_i == rs2_addr_d_i);
        load_use  = load_in_e && src_match;

        stall_o   = load_use;                     // hold decode one cycle
        flush_e_o = load_use || branch_taken_e_i; // bubble into execute
    end

endmodule

// ==== alu_execute.sv ====
`timescale 1ns/1ps

module alu_execute (
    input  rv_de_pkg::word_t   rs1_data_i,
    input  rv_de_pkg::word_t   rs2_data_i,
    input  rv_de_pkg::word_t   imm_ext_i,
    input  rv_de_pkg::word_t   pc_i,
    input  logic               alu_src_i,
    input  rv_de_pkg::alu_op_t alu_op_i,
    input  logic               branch_i,
    input  logic               branch_ne_i,
    input  logic               jump_i,
    output rv_de_pkg::word_t   alu_result_o,
    output rv_de_pkg::word_t   store_data_o,
    output logic               branch_taken_o,
    output rv_de_pkg::word_t   branch_target_o
);

    rv_de_pkg::word_t src_a;
    rv_de_pkg::word_t src_b;
    rv_de_pkg::word_t diff;
    logic [4:0]       shamt;
    logic             zero;
    logic             cond;

    assign src_a = rs1_data_i;
    assign src_b = alu_src_i ? imm_ext_i : rs2_data_i;
    assign diff  = src_a - src_b;
    assign shamt = src_b[4:0];

    always_comb begin
        case (alu_op_i)
            rv_de_pkg::ALU_ADD: alu_result_o = src_a + src_b;
            rv_de_pkg::ALU_SUB: alu_result_o = diff;
            rv_de_pkg::ALU_AND: alu_result_o = src_a & src_b;
            rv_de_pkg::ALU_OR:  alu_result_o = src_a | src_b;
            rv_de_pkg::ALU_XOR: alu_result_o = src_a ^ src_b;
            rv_de_pkg::ALU_SLT: begin
                alu_result_o = ($signed(src_a) < $signed(src_b)) ? 'd1 : 'd0;
            end
            rv_de_pkg::ALU_SLL: alu_result_o = src_a << shamt;
            rv_de_pkg::ALU_SRL: alu_result_o = src_a >> shamt;
            default:            alu_result_o = '0;
        endcase
    end

    // branches run with alu_src low, so diff is rs1 - rs2
    assign zero = (diff == '0);
    assign cond = branch_ne_i ? !zero : zero;

    assign branch_taken_o  = (branch_i && cond) || jump_i;
    assign branch_target_o = pc_i + imm_ext_i;
    assign store_data_o    = rs2_data_i;

endmodule

// ==== rv_de_core.sv ====
`timescale 1ns/1ps

module rv_de_core (
    input  logic                   clk,
    input  logic                   arst_n_i,
    input  rv_de_pkg::word_t       instr_i,
    input  rv_de_pkg::word_t       pc_i,
    input  logic                   instr_valid_i,
    input  logic                   wb_en_i,
    input  rv_de_pkg::reg_addr_t   wb_addr_i,
    input  rv_de_pkg::word_t       wb_data_i,
    output logic                   stall_o,
    output logic                   illegal_o,
    output logic                   reg_wr_en_o,
    output logic                   mem_wr_en_o,
    output rv_de_pkg::result_src_t result_src_o,
    output rv_de_pkg::reg_addr_t   wr_addr_o,
    output rv_de_pkg::word_t       alu_result_o,
    output rv_de_pkg::word_t       store_data_o,
    output rv_de_pkg::word_t       pc_plus_4_o,
    output logic                   branch_taken_o,
    output rv_de_pkg::word_t       branch_target_o
);

    // decode stage
    logic                   reg_wr_en_d;
    logic                   mem_wr_en_d;
    logic                   branch_d;
    logic                   branch_ne_d;
    logic                   jump_d;
    logic                   alu_src_d;
    rv_de_pkg::result_src_t result_src_d;
    rv_de_pkg::alu_op_t     alu_op_d;
    rv_de_pkg::word_t       imm_ext_d;
    rv_de_pkg::reg_addr_t   rs1_addr_d;
    rv_de_pkg::reg_addr_t   rs2_addr_d;
    rv_de_pkg::reg_addr_t   rd_addr_d;
    rv_de_pkg::word_t       rs1_data_d;
    rv_de_pkg::word_t       rs2_data_d;
    rv_de_pkg::word_t       pc_plus_4_d;

    // execute stage
    logic                   branch_e;
    logic                   branch_ne_e;
    logic                   jump_e;
    logic                   alu_src_e;
    rv_de_pkg::alu_op_t     alu_op_e;
    rv_de_pkg::word_t       imm_ext_e;
    rv_de_pkg::word_t       rs1_data_e;
    rv_de_pkg::word_t       rs2_data_e;
    rv_de_pkg::word_t       pc_e;
    logic                   flush_e;

    assign pc_plus_4_d = pc_i + 'd4; // link value for jal

    instr_decoder u_decoder (
        .instr_i       (instr_i),
        .instr_valid_i (instr_valid_i),
        .reg_wr_en_o   (reg_wr_en_d),
        .mem_wr_en_o   (mem_wr_en_d),
        .branch_o      (branch_d),
        .branch_ne_o   (branch_ne_d),
        .jump_o        (jump_d),
        .alu_src_o     (alu_src_d),
        .result_src_o  (result_src_d),
        .alu_op_o      (alu_op_d),
        .imm_ext_o     (imm_ext_d),
        .rs1_addr_o    (rs1_addr_d),
        .rs2_addr_o    (rs2_addr_d),
        .rd_addr_o     (rd_addr_d),
        .illegal_o     (illegal_o)
    );

    reg_file u_reg_file (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .rs1_addr_i (rs1_addr_d),
        .rs2_addr_i (rs2_addr_d),
        .rs1_data_o (rs1_data_d),
        .rs2_data_o (rs2_data_d),
        .wr_en_i    (wb_en_i),
        .wr_addr_i  (wb_addr_i),
        .wr_data_i  (wb_data_i)
    );

    pipeline_reg_d_e u_pipe_d_e (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .flush_i      (flush_e),
        .valid_i      (instr_valid_i),
        .reg_wr_en_i  (reg_wr_en_d),
        .mem_wr_en_i  (mem_wr_en_d),
        .branch_i     (branch_d),
        .branch_ne_i  (branch_ne_d),
        .jump_i       (jump_d),
        .alu_src_i    (alu_src_d),
        .result_src_i (result_src_d),
        .alu_op_i     (alu_op_d),
        .imm_ext_i    (imm_ext_d),
        .rd_addr_i    (rd_addr_d),
        .rs1_data_i   (rs1_data_d),
        .rs2_data_i   (rs2_data_d),
        .pc_i         (pc_i),
        .pc_plus_4_i  (pc_plus_4_d),
        .reg_wr_en_o  (reg_wr_en_o),
        .mem_wr_en_o  (mem_wr_en_o),
        .branch_o     (branch_e),
        .branch_ne_o  (branch_ne_e),
        .jump_o       (jump_e),
        .alu_src_o    (alu_src_e),
        .result_src_o (result_src_o),
        .alu_op_o     (alu_op_e),
        .imm_ext_o    (imm_ext_e),
        .rd_addr_o    (wr_addr_o),
        .rs1_data_o   (rs1_data_e),
        .rs2_data_o   (rs2_data_e),
        .pc_o         (pc_e),
        .pc_plus_4_o  (pc_plus_4_o)
    );

    hazard_unit u_hazard (
        .rs1_addr_d_i     (rs1_addr_d),
        .rs2_addr_d_i     (rs2_addr_d),
        .rd_addr_e_i      (wr_addr_o),
        .reg_wr_en_e_i    (reg_wr_en_o),
        .result_src_e_i   (result_src_o),
        .branch_taken_e_i (branch_taken_o),
        .stall_o          (stall_o),
        .flush_e_o        (flush_e)
    );

    alu_execute u_execute (
        .rs1_data_i      (rs1_data_e),
        .rs2_data_i      (rs2_data_e),
        .imm_ext_i       (imm_ext_e),
        .pc_i            (pc_e),
        .alu_src_i       (alu_src_e),
        .alu_op_i        (alu_op_e),
        .branch_i        (branch_e),
        .branch_ne_i     (branch_ne_e),
        .jump_i          (jump_e),
        .alu_result_o    (alu_result_o),
        .store_data_o    (store_data_o),
        .branch_taken_o  (branch_taken_o),
        .branch_target_o (branch_target_o)
    );

endmodule

// ==== tb_rv_de_core.sv ====
`timescale 1ns/1ps

module tb_rv_de_core;

    typedef struct packed {
        logic             wr_en;
        logic             mem_wr;
        logic [1:0]       res;
        logic [4:0]       rd;
        rv_de_pkg::word_t alu;
        logic             alu_chk;
        rv_de_pkg::word_t store;
        logic             st_chk;
        logic             taken;
        rv_de_pkg::word_t target;
        logic             tgt_chk;
        rv_de_pkg::word_t pc4;
        logic             link_chk;
    } exec_t;

    logic                   clk;
    logic                   arst_n_i;
    rv_de_pkg::word_t       instr_i;
    rv_de_pkg::word_t       pc_i;
    logic                   instr_valid_i;
    logic                   wb_en_i;
    rv_de_pkg::reg_addr_t   wb_addr_i;
    rv_de_pkg::word_t       wb_data_i;
    logic                   stall_o;
    logic                   illegal_o;
    logic                   reg_wr_en_o;
    logic                   mem_wr_en_o;
    rv_de_pkg::result_src_t result_src_o;
    rv_de_pkg::reg_addr_t   wr_addr_o;
    rv_de_pkg::word_t       alu_result_o;
    rv_de_pkg::word_t       store_data_o;
    rv_de_pkg::word_t       pc_plus_4_o;
    logic                   branch_taken_o;
    rv_de_pkg::word_t       branch_target_o;

    rv_de_pkg::word_t mregs [32]; // model copy of the register file
    exec_t            exe;        // model of what execute holds
    exec_t            exp_e;      // expectation for the coming posedge
    logic             exp_stall;
    logic             exp_illegal;
    logic             chk_en;
    rv_de_pkg::word_t cur_pc;
    string            test_name;
    int               err_value;
    int               err_other;
    int               seed;

    rv_de_core u_dut (.*);

    always #5 clk = ~clk;

    function automatic rv_de_pkg::word_t alu_model(input rv_de_pkg::word_t a,
            input rv_de_pkg::word_t b, input logic [2:0] f3, input logic sub);
        case (f3)
            3'b000:  return sub ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:  return a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic void predict_exec(input rv_de_pkg::word_t ins, input rv_de_pkg::word_t pcv);
        rv_de_pkg::word_t a;
        rv_de_pkg::word_t b;
        rv_de_pkg::word_t imm_i;
        rv_de_pkg::word_t imm_s;
        rv_de_pkg::word_t imm_b;
        rv_de_pkg::word_t imm_j;
        a     = mregs[ins[19:15]];
        b     = mregs[ins[24:20]];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        exe    = '0;
        exe.rd = ins[11:7];
        case (ins[6:0])
            7'b0110011: begin
                exe.wr_en = 1'b1; exe.alu_chk = 1'b1;
                exe.alu   = alu_model(a, b, ins[14:12], ins[30]);
            end
            7'b0010011: begin
                exe.wr_en = 1'b1; exe.alu_chk = 1'b1;
                exe.alu   = alu_model(a, imm_i, ins[14:12], 1'b0);
            end
            7'b0000011: begin
                exe.wr_en = 1'b1; exe.res = 2'd1;
                exe.alu   = a + imm_i; exe.alu_chk = 1'b1;
            end
            7'b0100011: begin
                exe.mem_wr = 1'b1; exe.alu = a + imm_s; exe.alu_chk = 1'b1;
                exe.store  = b; exe.st_chk = 1'b1;
            end
            7'b1100011: begin // beq or bne by funct3 bit 0
                exe.taken  = ins[12] ? (a != b) : (a == b);
                exe.target = pcv + imm_b; exe.tgt_chk = 1'b1;
            end
            7'b1101111: begin
                exe.wr_en  = 1'b1; exe.res = 2'd2; exe.taken = 1'b1;
                exe.target = pcv + imm_j; exe.tgt_chk = 1'b1;
                exe.pc4    = pcv + 32'd4; exe.link_chk = 1'b1;
            end
            default: ; // unknown opcode writes nothing
        endcase
    endfunction

    function automatic rv_de_pkg::word_t enc_r(input logic f7b, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
        return {1'b0, f7b, 5'b0, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic rv_de_pkg::word_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
            input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic rv_de_pkg::word_t enc_s(input logic [11:0] imm, input logic [4:0] rs2,
            input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic rv_de_pkg::word_t enc_b(input logic [12:0] imm, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic rv_de_pkg::word_t enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    // one falling edge: publish what execute holds, drive decode, predict the next state
    task automatic cycle_step(input rv_de_pkg::word_t ins, input logic vld, input string name);
        logic lu;
        logic known;
        @(negedge clk);
        exp_e         = exe;
        chk_en        = 1'b1;
        test_name     = name;
        instr_i       = ins;
        pc_i          = cur_pc;
        instr_valid_i = vld;
        lu = exe.wr_en && (exe.res == 2'd1) && (exe.rd != 5'd0) &&
             ((exe.rd == ins[19:15]) || (exe.rd == ins[24:20]));
        known = (ins[6:0] == 7'b0110011) || (ins[6:0] == 7'b0010011) ||
                (ins[6:0] == 7'b0000011) || (ins[6:0] == 7'b0100011) ||
                (ins[6:0] == 7'b1100011) || (ins[6:0] == 7'b1101111);
        exp_stall   = lu;
        exp_illegal = vld && !known;
        if (lu || exe.taken || !vld) begin
            exe = '0; // bubble
        end else begin
            predict_exec(ins, cur_pc);
        end
    endtask

    task automatic issue(input rv_de_pkg::word_t ins, input logic vld, input string name);
        int waited;
        waited = 0;
        cycle_step(ins, vld, name);
        #1;
        while (stall_o && waited < 8) begin // held until the stall clears
            waited++;
            cycle_step(ins, vld, name);
            #1;
        end
        if (stall_o) begin
            $display("stall_o did not fall within 8 cycles during %s", name);
            err_other++;
        end
        cur_pc = cur_pc + 32'd4;
    endtask

    a_reset: assert property (@(posedge clk)
        !arst_n_i |-> (!reg_wr_en_o && !mem_wr_en_o && !branch_taken_o && !stall_o))
        else begin
            err_other++;
            $display("outputs were not cleared while reset was held");
        end

    a_enables: assert property (@(posedge clk) disable iff (!arst_n_i)
        chk_en |-> (reg_wr_en_o == exp_e.wr_en && mem_wr_en_o == exp_e.mem_wr &&
                    branch_taken_o == exp_e.taken))
        else begin
            err_value++;
            $display("Error: %s enables expected %b%b%b actual %b%b%b", test_name,
                     exp_e.wr_en, exp_e.mem_wr, exp_e.taken, $sampled(reg_wr_en_o),
                     $sampled(mem_wr_en_o), $sampled(branch_taken_o));
        end

    a_result: assert property (@(posedge clk) disable iff (!arst_n_i)
        (chk_en && exp_e.alu_chk) |-> (alu_result_o == exp_e.alu))
        else begin
            err_value++;
            $display("Error: %s alu_result expected %h actual %h", test_name, exp_e.alu,
                     $sampled(alu_result_o));
        end

    a_dest: assert property (@(posedge clk) disable iff (!arst_n_i)
        (chk_en && exp_e.wr_en) |-> (wr_addr_o == exp_e.rd && result_src_o == exp_e.res))
        else begin
            err_value++;
            $display("Error: %s rd/src expected %h/%h actual %h/%h", test_name, exp_e.rd,
                     exp_e.res, $sampled(wr_addr_o), $sampled(result_src_o));
        end

    a_store: assert property (@(posedge clk) disable iff (!arst_n_i)
        (chk_en && exp_e.st_chk) |-> (store_data_o == exp_e.store))
        else begin
            err_value++;
            $display("Error: %s store_data expected %h actual %h", test_name, exp_e.store,
                     $sampled(store_data_o));
        end

    a_target: assert property (@(posedge clk) disable iff (!arst_n_i)
        (chk_en && exp_e.tgt_chk) |-> (branch_target_o == exp_e.target))
        else begin
            err_value++;
            $display("Error: %s branch_target expected %h actual %h", test_name, exp_e.target,
                     $sampled(branch_target_o));
        end

    a_link: assert property (@(posedge clk) disable iff (!arst_n_i)
        (chk_en && exp_e.link_chk) |-> (pc_plus_4_o == exp_e.pc4))
        else begin
            err_value++;
            $display("Error: %s pc_plus_4 expected %h actual %h", test_name, exp_e.pc4,
                     $sampled(pc_plus_4_o));
        end

    a_hazard: assert property (@(posedge clk) disable iff (!arst_n_i)
        chk_en |-> (stall_o == exp_stall && illegal_o == exp_illegal))
        else begin
            err_value++;
            $display("Error: %s stall/illegal expected %b/%b actual %b/%b", test_name,
                     exp_stall, exp_illegal, $sampled(stall_o), $sampled(illegal_o));
        end

    a_stall_once: assert property (@(posedge clk) disable iff (!arst_n_i)
        stall_o |=> !stall_o)
        else begin
            err_other++;
            $display("stall_o stayed high for more than one cycle during %s", test_name);
        end

    initial begin
        #200000;
        $display("simulation did not finish in time");
        $display("test failed");
        $finish;
    end

    initial begin
        seed = 70;
        clk = 1'b0;
        arst_n_i = 1'b1;
        instr_i = '0;
        pc_i = '0;
        instr_valid_i = 1'b0;
        wb_en_i = 1'b0;
        wb_addr_i = '0;
        wb_data_i = '0;
        exe = '0;
        exp_e = '0;
        exp_stall = 1'b0;
        exp_illegal = 1'b0;
        chk_en = 1'b0;
        cur_pc = 32'h100;
        err_value = 0;
        err_other = 0;
        test_name = "reset";
        for (int i = 0; i < 32; i++) begin
            mregs[i] = '0;
        end
        #1 arst_n_i = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk) arst_n_i = 1'b1;

        for (int i = 1; i < 16; i++) begin
            @(negedge clk);
            wb_en_i   = 1'b1;
            wb_addr_i = 5'(i);
            wb_data_i = $random(seed);
            mregs[i]  = wb_data_i;
        end
        @(negedge clk) wb_en_i = 1'b0;

        for (int f = 0; f < 8; f++) begin
            if (f != 3) begin
                issue(enc_r(1'b0, 5'(f + 2), 5'(f + 1), 3'(f), 5'(16 + f)), 1'b1, "r_type");
            end
        end
        issue(enc_r(1'b1, 5'd4, 5'd3, 3'b000, 5'd24), 1'b1, "r_sub");
        issue(enc_i(12'hff9, 5'd5, 3'b000, 5'd25, 7'b0010011), 1'b1, "addi");
        issue(enc_i(12'h0f3, 5'd6, 3'b111, 5'd26, 7'b0010011), 1'b1, "andi");
        issue(enc_i(12'h801, 5'd7, 3'b110, 5'd27, 7'b0010011), 1'b1, "ori");
        issue(enc_i(12'h5a5, 5'd8, 3'b100, 5'd28, 7'b0010011), 1'b1, "xori");
        issue(enc_i(12'hfff, 5'd9, 3'b010, 5'd29, 7'b0010011), 1'b1, "slti");
        issue(enc_i(12'h008, 5'd6, 3'b010, 5'd21, 7'b0000011), 1'b1, "lw_addr");
        issue(enc_s(12'hffc, 5'd7, 5'd8), 1'b1, "sw");
        issue(enc_b(13'h010, 5'd1, 5'd1, 3'b000), 1'b1, "beq_taken");
        issue(enc_r(1'b0, 5'd2, 5'd1, 3'b000, 5'd30), 1'b1, "after_beq");
        issue(enc_b(13'h1ff0, 5'd2, 5'd1, 3'b001), 1'b1, "bne");
        issue(enc_r(1'b0, 5'd2, 5'd1, 3'b000, 5'd30), 1'b1, "after_bne");
        issue(enc_b(13'h020, 5'd2, 5'd1, 3'b000), 1'b1, "beq_not_taken");
        issue(enc_j(21'h00010, 5'd22), 1'b1, "jal");
        issue(enc_r(1'b0, 5'd3, 5'd2, 3'b110, 5'd31), 1'b1, "after_jal");
        issue(enc_i(12'h000, 5'd1, 3'b010, 5'd23, 7'b0000011), 1'b1, "lw_use");
        issue(enc_r(1'b0, 5'd2, 5'd23, 3'b000, 5'd24), 1'b1, "load_use");
        issue(32'h0000007f, 1'b1, "illegal");
        issue('0, 1'b0, "invalid_slot");
        repeat (3) begin
            issue('0, 1'b0, "drain");
        end
        @(negedge clk) chk_en = 1'b0;
        @(negedge clk);

        $display("errors: %0d wrong values, %0d other failures", err_value, err_other);
        if (err_value == 0 && err_other == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== rv_de.f ====
+incdir+.
rv_de_pkg.sv
instr_decoder.sv
reg_file.sv
pipeline_reg_d_e.sv
hazard_unit.sv
alu_execute.sv
rv_de_core.sv
tb_rv_de_core.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile and run the rv_de testbench with Verilator.

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert \
    -f rv_de.f \
    --top-module tb_rv_de_core \
    -Mdir obj_dir > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    echo "compile failed, see $BUILD_LOG"
    exit 1
fi

./obj_dir/Vtb_rv_de_core > "$SIM_LOG" 2>&1
run_status=$?
cat "$SIM_LOG"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "test failed" "$SIM_LOG"; then
    echo "FAIL"
    exit 1
fi

if ! grep -q "test passed" "$SIM_LOG"; then
    echo "no result line found in $SIM_LOG"
    exit 1
fi

echo "PASS"
exit 0
